//--- project.f
verilog/mac_ctrl_pkg.sv
verilog/rx_frame_classifier.sv
verilog/ack_responder.sv
verilog/retrans_controller.sv
verilog/resp_frame_builder.sv
verilog/tx_control_top.sv
testbench/clk_gen.sv
testbench/tb_tx_control.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the tx control testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f \
  --top-module tb_tx_control -Mdir obj_dir -o sim_tx_control

./obj_dir/sim_tx_control 2>&1 | tee sim.log

if grep -q "Verification failed" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

//--- testbench/clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rstn
);

  initial begin
    clk  = 1'b0;
    rstn = 1'b0;
    // released on the edge after five cycles
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
  end

  // 20 ns period
  always #10 clk = ~clk;

endmodule

//--- testbench/tb_tx_control.sv
// tx control unit testbench
`timescale 1ns/1ps

module tb_tx_control;

  logic                      clk;
  logic                      rstn;
  mac_ctrl_pkg::rx_hdr_t     rx_hdr;
  logic                      sig_valid;
  logic                      fcs_strobe;
  logic                      fcs_valid;
  logic                      tx_done;
  logic                      tx_need_ack;
  mac_ctrl_pkg::retry_t      tx_retry_limit;
  logic                      backoff_done;
  logic                      quit_retrans;
  mac_ctrl_pkg::ctrl_cfg_t   cfg;
  logic                      resp_ready;
  logic                      resp_valid;
  mac_ctrl_pkg::resp_frame_t resp_frame;
  logic                      tx_try_complete;
  mac_ctrl_pkg::tx_status_t  tx_status;
  logic                      start_retrans;
  logic                      retrans_trigger;
  logic                      retrans_in_progress;

  mac_ctrl_pkg::resp_frame_t resp_q[$];
  mac_ctrl_pkg::tx_status_t  status_q[$];
  int                        value_errs = 0;
  int                        other_errs = 0;
  int                        n_trig = 0;
  int                        n_start = 0;
  logic                      bp_en = 1'b0;
  logic                      stalled = 1'b0;
  mac_ctrl_pkg::resp_frame_t stalled_frame;

  clk_gen u_clk (.clk(clk), .rstn(rstn));

  tx_control_top dut (
    .clk(clk), .rstn(rstn), .rx_hdr(rx_hdr), .sig_valid(sig_valid),
    .fcs_strobe(fcs_strobe), .fcs_valid(fcs_valid), .tx_done(tx_done),
    .tx_need_ack(tx_need_ack), .tx_retry_limit(tx_retry_limit),
    .backoff_done(backoff_done), .quit_retrans(quit_retrans), .cfg(cfg),
    .resp_ready(resp_ready), .resp_valid(resp_valid), .resp_frame(resp_frame),
    .tx_try_complete(tx_try_complete), .tx_status(tx_status),
    .start_retrans(start_retrans), .retrans_trigger(retrans_trigger),
    .retrans_in_progress(retrans_in_progress)
  );

  // does the standard call for a response at all
  function automatic logic answer_expected(mac_ctrl_pkg::rx_hdr_t h, logic fcs_ok,
                                           mac_ctrl_pkg::ctrl_cfg_t c);
    logic kind_ok;
    kind_ok = 1'b0;
    if (h.fc_type == 2'b00) kind_ok = (h.fc_subtype != 4'b1110);
    if (h.fc_type == 2'b10) kind_ok = !h.fc_subtype[3] || (h.qos_ack_policy == 2'b00);
    if (h.fc_type == 2'b01) begin
      kind_ok = (h.fc_subtype == 4'b1000) || (h.fc_subtype == 4'b1010) ||
                ((h.fc_subtype == 4'b1011) && (h.sig_len == 12'd20) && !c.cts_disable);
    end
    return kind_ok && fcs_ok && (h.addr1 == c.self_addr) && !c.ack_disable;
  endfunction

  function automatic mac_ctrl_pkg::resp_frame_t exp_resp(mac_ctrl_pkg::rx_hdr_t h,
                                                         mac_ctrl_pkg::ctrl_cfg_t c);
    mac_ctrl_pkg::resp_frame_t f;
    int   rx_us;
    int   ack_us;
    int   term;
    logic is_rts;
    is_rts = (h.fc_type == 2'b01) && (h.fc_subtype == 4'b1011);
    // aid values carry no time
    rx_us  = h.duration[15] ? 0 : int'(h.duration);
    ack_us = int'(c.preamble_sig_us) + 6 * int'(c.ofdm_sym_us) + int'(c.sifs_us);
    term   = 0;
    if ((is_rts || (h.more_frag && h.fc_type != 2'b01)) && rx_us > ack_us) term = rx_us - ack_us;
    f            = '0;
    f.signal[3:0]  = c.resp_rate;
    f.signal[16:5] = 12'd14;
    f.signal[17]   = ^{c.resp_rate, 12'd14};
    f.fc_subtype = is_rts ? 4'b1100 : 4'b1101;
    f.duration   = 16'(int'(c.duration_extra) + term);
    f.ra         = h.addr2;
    return f;
  endfunction

  // misses before the end, then ack or give up
  function automatic mac_ctrl_pkg::tx_status_t exp_status(int misses, logic acked_end,
                                                          mac_ctrl_pkg::retry_t lim);
    mac_ctrl_pkg::retry_t r;
    r = '0;
    for (int i = 0; i < misses; i++) begin
      if (r == lim || lim == '0) return '{acked: 1'b0, retries: r};
      r = r + 4'd1;
    end
    return '{acked: acked_end, retries: r};
  endfunction

  task automatic check_resp(string name, mac_ctrl_pkg::resp_frame_t exp,
                            mac_ctrl_pkg::resp_frame_t act);
    if (act !== exp) begin
      value_errs++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_status(string name, mac_ctrl_pkg::tx_status_t exp,
                              mac_ctrl_pkg::tx_status_t act);
    if (act !== exp) begin
      value_errs++;
      $display("error %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (act !== exp) begin
      value_errs++;
      $display("error %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_count(string name, int exp, int act);
    if (act != exp) begin
      value_errs++;
      $display("error %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  // scoreboard side, sampled on the edge
  always @(posedge clk) begin
    if (rstn) begin
      if (stalled && !resp_valid) begin
        other_errs++;
        $display("resp_valid dropped while the output was stalled");
      end else if (stalled && resp_frame !== stalled_frame) begin
        other_errs++;
        $display("resp_frame changed while the output was stalled");
      end
      stalled       = resp_valid && !resp_ready;
      stalled_frame = resp_frame;
      if (resp_valid && resp_ready) resp_q.push_back(resp_frame);
      if (tx_try_complete) status_q.push_back(tx_status);
      if (retrans_trigger) n_trig++;
      if (start_retrans) n_start++;
    end
  end

  // random back-pressure when enabled
  always @(posedge clk) begin
    resp_ready <= bp_en ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  task automatic send_frame(mac_ctrl_pkg::rx_hdr_t h, logic fcs);
    @(posedge clk);
    rx_hdr     <= h;
    fcs_valid  <= fcs;
    fcs_strobe <= 1'b1;
    @(posedge clk);
    fcs_strobe <= 1'b0;
  endtask

  task automatic pulse_tx_done(logic need_ack, mac_ctrl_pkg::retry_t lim);
    @(posedge clk);
    tx_done        <= 1'b1;
    tx_need_ack    <= need_ack;
    tx_retry_limit <= lim;
    @(posedge clk);
    tx_done     <= 1'b0;
    tx_need_ack <= 1'b0;
  endtask

  task automatic pulse_backoff();
    @(posedge clk);
    backoff_done <= 1'b1;
    @(posedge clk);
    backoff_done <= 1'b0;
  endtask

  task automatic pulse_quit();
    @(posedge clk);
    quit_retrans <= 1'b1;
    @(posedge clk);
    quit_retrans <= 1'b0;
  endtask

  function automatic mac_ctrl_pkg::rx_hdr_t rand_hdr(int sel);
    mac_ctrl_pkg::rx_hdr_t h;
    h                = '0;
    h.addr1          = ($urandom_range(0, 3) != 0) ? cfg.self_addr : {16'($urandom), $urandom};
    h.addr2          = {16'($urandom), $urandom};
    h.more_frag      = 1'($urandom_range(0, 1));
    h.qos_ack_policy = 2'($urandom);
    h.duration       = {1'($urandom_range(0, 3) == 0), 15'($urandom_range(0, 2000))};
    h.sig_len        = 12'd40 + 12'($urandom_range(0, 200));
    case (sel)
      0: begin
        h.fc_type    = 2'b10;
        h.fc_subtype = {1'b0, 3'($urandom)};
      end
      1: begin
        h.fc_type    = 2'b10;
        h.fc_subtype = {1'b1, 3'($urandom)};
      end
      2: begin
        h.fc_type    = 2'b00;
        h.fc_subtype = 4'($urandom);
      end
      3: begin
        h.fc_type    = 2'b01;
        h.fc_subtype = 4'b1010;
      end
      default: begin
        h.fc_type    = 2'b01;
        h.fc_subtype = 4'b1011;
        h.sig_len    = 12'd20;
      end
    endcase
    return h;
  endfunction

  task automatic response_test(string name, mac_ctrl_pkg::rx_hdr_t h, logic fcs);
    int i;
    send_frame(h, fcs);
    if (answer_expected(h, fcs, cfg)) begin
      for (i = 0; i < 300 && resp_q.size() == 0; i++) @(posedge clk);
      if (resp_q.size() == 0) begin
        other_errs++;
        $display("no response seen for %s", name);
      end else begin
        check_resp(name, exp_resp(h, cfg), resp_q.pop_front());
      end
      // end of our own response on air
      pulse_tx_done(1'b0, '0);
      @(posedge clk);
    end else begin
      repeat (int'(cfg.sifs_wait) + 20) @(posedge clk);
      if (resp_q.size() != 0) begin
        other_errs++;
        $display("unexpected response for %s", name);
        resp_q.delete();
      end
    end
  endtask

  // returns 1 on retrans_trigger, 0 on completion
  task automatic wait_retry_or_done(output logic got_retry);
    int i;
    got_retry = 1'b0;
    for (i = 0; i < 300; i++) begin
      @(posedge clk);
      if (retrans_trigger) begin
        got_retry = 1'b1;
        break;
      end
      if (tx_try_complete) break;
    end
    if (i == 300) begin
      other_errs++;
      $display("timed out waiting for a retry or completion");
    end
  endtask

  task automatic send_ack_reply();
    mac_ctrl_pkg::rx_hdr_t h;
    h            = '0;
    h.fc_type    = 2'b01;
    h.fc_subtype = 4'b1101;
    h.addr1      = cfg.self_addr;
    h.sig_len    = 12'd14;
    @(posedge clk);
    rx_hdr    <= h;
    sig_valid <= 1'b1;
    @(posedge clk);
    sig_valid <= 1'b0;
    repeat (3) @(posedge clk);
    send_frame(h, 1'b1);
  endtask

  task automatic attempt_test(string name, int misses, logic acked_end,
                              mac_ctrl_pkg::retry_t lim, logic use_quit);
    logic got_retry;
    int   i;
    n_trig  = 0;
    n_start = 0;
    pulse_tx_done(1'b1, lim);
    // attempt level is up once the data frame is out
    @(posedge clk);
    check_flag({name, " in progress"}, 1'b1, retrans_in_progress);
    for (int k = 0; k < 16; k++) begin
      if (k >= misses) begin
        send_ack_reply();
        break;
      end
      wait_retry_or_done(got_retry);
      if (!got_retry) break;
      if (use_quit) begin
        pulse_quit();
        break;
      end
      pulse_backoff();
      for (i = 0; i < 50 && n_start <= k; i++) @(posedge clk);
      if (n_start <= k) begin
        other_errs++;
        $display("start_retrans missing in %s", name);
      end
      pulse_tx_done(1'b1, lim);
    end
    for (i = 0; i < 300 && status_q.size() == 0; i++) @(posedge clk);
    if (status_q.size() == 0) begin
      other_errs++;
      $display("no completion seen for %s", name);
    end else begin
      check_status(name, exp_status(misses, acked_end, lim), status_q.pop_front());
      check_flag({name, " in progress"}, 1'b0, retrans_in_progress);
    end
  endtask

  initial begin
    int i;
    mac_ctrl_pkg::rx_hdr_t h;
    void'($urandom(32'ha74b_683e));
    rx_hdr = '0;
    sig_valid = 1'b0;
    fcs_strobe = 1'b0;
    fcs_valid = 1'b0;
    tx_done = 1'b0;
    tx_need_ack = 1'b0;
    tx_retry_limit = '0;
    backoff_done = 1'b0;
    quit_retrans = 1'b0;
    resp_ready = 1'b1;
    cfg = '{self_addr: 48'h02_1a_3c_55_7e_91, ack_disable: 1'b0, cts_disable: 1'b0,
           resp_rate: 4'hb, preamble_sig_us: 9'd20, ofdm_sym_us: 9'd4, sifs_us: 9'd16,
           duration_extra: 16'd5, sifs_wait: 15'd3, sig_timeout: 15'd10,
           ack_timeout: 15'd12, max_retrans: '0};
    for (i = 0; i < 100 && !rstn; i++) @(posedge clk);
    if (!rstn) begin
      other_errs++;
      $display("reset never released");
    end
    // responses under random back-pressure
    bp_en = 1'b1;
    for (int n = 0; n < 60; n++) begin
      response_test("random frame", rand_hdr($urandom_range(0, 4)), $urandom_range(0, 4) != 0);
    end
    cfg.cts_disable <= 1'b1;
    for (int n = 0; n < 4; n++) begin
      h = rand_hdr(4);
      h.addr1 = cfg.self_addr;
      response_test("rts with cts disabled", h, 1'b1);
    end
    cfg.cts_disable <= 1'b0;
    cfg.ack_disable <= 1'b1;
    for (int n = 0; n < 8; n++) begin
      h = rand_hdr(n % 5);
      h.addr1 = cfg.self_addr;
      response_test("ack disabled", h, 1'b1);
    end
    cfg.ack_disable <= 1'b0;
    bp_en = 1'b0;
    // own transmissions
    pulse_tx_done(1'b0, 4'd3);
    for (i = 0; i < 50 && status_q.size() == 0; i++) @(posedge clk);
    if (status_q.size() == 0) begin
      other_errs++;
      $display("no completion seen for tx without ack");
    end else begin
      check_status("no ack needed", exp_status(0, 1'b1, 4'd3), status_q.pop_front());
      check_flag("no ack needed in progress", 1'b0, retrans_in_progress);
    end
    attempt_test("acked first try", 0, 1'b1, 4'd3, 1'b0);
    attempt_test("acked after one miss", 1, 1'b1, 4'd3, 1'b0);
    attempt_test("retry limit reached", 16, 1'b0, 4'd2, 1'b0);
    check_count("retrans_trigger count", 2, n_trig);
    check_count("start_retrans count", 2, n_start);
    attempt_test("quit after one miss", 1, 1'b0, 4'd3, 1'b1);
    repeat (5) @(posedge clk);
    $display("value errors %0d, other errors %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // overall bound on the run
  initial begin
    #5ms;
    $display("simulation did not finish in time");
    $display("Verification failed");
    $finish;
  end

endmodule

//--- verilog/ack_responder.sv
// ack and cts responder
`timescale 1ns/1ps

module ack_responder (
  input  logic                      clk,
  input  logic                      rstn,
  input  mac_ctrl_pkg::rx_evt_t     rx_evt,
  input  logic                      rx_evt_valid,
  input  mac_ctrl_pkg::ctrl_cfg_t   cfg,
  input  logic                      tx_done,
  input  logic                      req_ready,
  output mac_ctrl_pkg::resp_req_t   req,
  output logic                      req_valid,
  output logic                      resp_busy
);

  mac_ctrl_pkg::resp_state_e state;
  mac_ctrl_pkg::tick_t       wait_cnt;
  mac_ctrl_pkg::dur_t        ack_sifs_us;
  mac_ctrl_pkg::dur_t        dur_rx;
  mac_ctrl_pkg::dur_t        dur_term;
  logic                      kind_ok;
  logic                      use_term;
  logic                      answer;

  always_comb begin
    case (rx_evt.kind)
      mac_ctrl_pkg::kind_data,
      mac_ctrl_pkg::kind_qos_data,
      mac_ctrl_pkg::kind_mgmt,
      mac_ctrl_pkg::kind_bar,
      mac_ctrl_pkg::kind_pspoll: kind_ok = 1'b1;
      mac_ctrl_pkg::kind_rts:    kind_ok = !cfg.cts_disable;
      default:                   kind_ok = 1'b0;
    endcase
  end

  // frames arriving while busy are dropped
  assign answer = rx_evt_valid && (state == mac_ctrl_pkg::resp_idle) && rx_evt.fcs_ok &&
                  rx_evt.to_self && kind_ok && !cfg.ack_disable;

  // only rts and fragment bursts reserve time past the response
  assign use_term = (rx_evt.kind == mac_ctrl_pkg::kind_rts) ||
                    (rx_evt.more_frag && (rx_evt.kind inside {mac_ctrl_pkg::kind_data,
                                                               mac_ctrl_pkg::kind_qos_data,
                                                               mac_ctrl_pkg::kind_mgmt}));

  // bit 15 set is an aid, not a time
  assign dur_rx = rx_evt.duration[15] ? '0 : rx_evt.duration;

  // remaining nav, clamped at zero
  assign dur_term = (use_term && (dur_rx > ack_sifs_us)) ? (dur_rx - ack_sifs_us) : '0;

  // ack airtime plus sifs, from static cfg
  always_ff @(posedge clk) begin
    ack_sifs_us <= mac_ctrl_pkg::dur_t'(cfg.preamble_sig_us) +
                   mac_ctrl_pkg::dur_t'(mac_ctrl_pkg::ACK_NSYM) *
                   mac_ctrl_pkg::dur_t'(cfg.ofdm_sym_us) +
                   mac_ctrl_pkg::dur_t'(cfg.sifs_us);
  end

  // order payload, frozen until back in idle
  always_ff @(posedge clk) begin
    if (answer) begin
      req.is_cts   <= (rx_evt.kind == mac_ctrl_pkg::kind_rts);
      req.duration <= cfg.duration_extra + dur_term;
      req.ra       <= rx_evt.ta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= mac_ctrl_pkg::resp_idle;
      wait_cnt <= '0;
    end else begin
      case (state)
        mac_ctrl_pkg::resp_idle: begin
          if (answer) begin
            // zero wait goes straight to send
            wait_cnt <= 15'd1;
            state    <= (cfg.sifs_wait == '0) ? mac_ctrl_pkg::resp_send : mac_ctrl_pkg::resp_prep;
          end
        end
        mac_ctrl_pkg::resp_prep: begin
          // sifs countdown
          if (wait_cnt == cfg.sifs_wait) begin
            state <= mac_ctrl_pkg::resp_send;
          end else begin
            wait_cnt <= wait_cnt + 15'd1;
          end
        end
        mac_ctrl_pkg::resp_send: begin
          if (req_ready) state <= mac_ctrl_pkg::resp_wait_done;
        end
        mac_ctrl_pkg::resp_wait_done: begin
          // phy finished sending our response
          if (tx_done) state <= mac_ctrl_pkg::resp_idle;
        end
        default: state <= mac_ctrl_pkg::resp_idle;
      endcase
    end
  end

  assign req_valid = (state == mac_ctrl_pkg::resp_send);
  assign resp_busy = (state != mac_ctrl_pkg::resp_idle);

  // order held under builder back-pressure
  assert property (@(posedge clk) disable iff (!rstn)
    req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

//--- verilog/mac_ctrl_pkg.sv
// mac tx control shared types
package mac_ctrl_pkg;

  // field widths with protocol meaning
  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] dur_t;
  typedef logic [11:0] sig_len_t;
  typedef logic [3:0]  rate_t;
  typedef logic [3:0]  retry_t;
  typedef logic [14:0] tick_t;
  typedef logic [8:0]  usec_t;

  // ack and cts share one length
  localparam sig_len_t ACK_LEN = 12'd14;
  // 14 bytes at the base rate
  localparam int unsigned ACK_NSYM = 6;

  typedef enum logic [2:0] {
    kind_other,
    kind_data,
    kind_qos_data,
    kind_mgmt,
    kind_bar,
    kind_pspoll,
    kind_rts,
    kind_ack
  } frame_kind_e;

  typedef enum logic [1:0] {
    resp_idle,
    resp_prep,
    resp_send,
    resp_wait_done
  } resp_state_e;

  typedef enum logic [1:0] {
    rtx_idle,
    rtx_wait_tx_end,
    rtx_wait_sig,
    rtx_wait_ack
  } rtx_state_e;

  // header fields from the rx parser
  typedef struct packed {
    logic [1:0] fc_type;
    logic [3:0] fc_subtype;
    logic       more_frag;
    logic [1:0] qos_ack_policy;
    dur_t       duration;
    mac_addr_t  addr1;
    mac_addr_t  addr2;
    sig_len_t   sig_len;
  } rx_hdr_t;

  typedef struct packed {
    frame_kind_e kind;
    logic        to_self;
    logic        fcs_ok;
    logic        more_frag;
    dur_t        duration;
    mac_addr_t   ta;
    logic        ack_sig;
  } rx_evt_t;

  // static, written by software
  typedef struct packed {
    mac_addr_t self_addr;
    logic      ack_disable;
    logic      cts_disable;
    rate_t     resp_rate;
    usec_t     preamble_sig_us;
    usec_t     ofdm_sym_us;
    usec_t     sifs_us;
    dur_t      duration_extra;
    tick_t     sifs_wait;
    tick_t     sig_timeout;
    tick_t     ack_timeout;
    retry_t    max_retrans;
  } ctrl_cfg_t;

  typedef struct packed {
    logic      is_cts;
    dur_t      duration;
    mac_addr_t ra;
  } resp_req_t;

  typedef struct packed {
    logic [23:0] signal;
    logic [3:0]  fc_subtype;
    dur_t        duration;
    mac_addr_t   ra;
  } resp_frame_t;

  typedef struct packed {
    logic   acked;
    retry_t retries;
  } tx_status_t;

endpackage

//--- verilog/resp_frame_builder.sv
// ack and cts descriptor builder
`timescale 1ns/1ps

module resp_frame_builder (
  input  logic                        clk,
  input  logic                        rstn,
  input  mac_ctrl_pkg::resp_req_t     req,
  input  logic                        req_valid,
  input  mac_ctrl_pkg::rate_t         resp_rate,
  input  logic                        resp_ready,
  output logic                        req_ready,
  output mac_ctrl_pkg::resp_frame_t   resp_frame,
  output logic                        resp_valid
);

  logic parity;
  logic take;

  // even parity over rate and length
  assign parity = ^{resp_rate, mac_ctrl_pkg::ACK_LEN};

  // single entry, free when empty or draining
  assign req_ready = !resp_valid || resp_ready;
  assign take      = req_valid && req_ready;

  always_ff @(posedge clk) begin
    if (take) begin
      // tail, parity, length, reserved, rate
      resp_frame.signal     <= {6'd0, parity, mac_ctrl_pkg::ACK_LEN, 1'b0, resp_rate};
      // cts 1100, ack 1101
      resp_frame.fc_subtype <= req.is_cts ? 4'b1100 : 4'b1101;
      resp_frame.duration   <= req.duration;
      resp_frame.ra         <= req.ra;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      resp_valid <= 1'b0;
    end else if (take) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

endmodule

//--- verilog/retrans_controller.sv
// ack wait and retransmission control
`timescale 1ns/1ps

module retrans_controller (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      tx_done,
  input  logic                      tx_need_ack,
  input  mac_ctrl_pkg::retry_t      tx_retry_limit,
  input  logic                      resp_busy,
  input  logic                      ack_sig,
  input  mac_ctrl_pkg::rx_evt_t     rx_evt,
  input  logic                      rx_evt_valid,
  input  logic                      backoff_done,
  input  logic                      quit_retrans,
  input  mac_ctrl_pkg::ctrl_cfg_t   cfg,
  output logic                      tx_try_complete,
  output mac_ctrl_pkg::tx_status_t  tx_status,
  output logic                      start_retrans,
  output logic                      retrans_trigger,
  output logic                      retrans_in_progress
);

  mac_ctrl_pkg::rtx_state_e state;
  mac_ctrl_pkg::tick_t      cnt;
  mac_ctrl_pkg::retry_t     retries;
  mac_ctrl_pkg::retry_t     limit;
  logic                     retry_pending;
  logic                     own_tx_end;
  logic                     ack_ok;
  logic                     timeout;
  logic                     last_try;
  logic                     done_ev;
  logic                     done_acked;
  logic                     retry_ev;
  logic                     start_ev;

  // tx_done during a response belongs to the responder
  assign own_tx_end = tx_done && !resp_busy;

  assign ack_ok = rx_evt_valid && (rx_evt.kind == mac_ctrl_pkg::kind_ack) &&
                  rx_evt.to_self && rx_evt.fcs_ok;

  // ack_sig or ack_ok in the last cycle still wins
  assign timeout = ((state == mac_ctrl_pkg::rtx_wait_sig) && !ack_sig &&
                    (cnt == cfg.sig_timeout)) ||
                   ((state == mac_ctrl_pkg::rtx_wait_ack) && !ack_ok &&
                    (cnt == cfg.ack_timeout));

  assign last_try = (retries == limit) || (limit == '0);

  always_comb begin
    done_ev    = 1'b0;
    done_acked = 1'b0;
    retry_ev   = 1'b0;
    start_ev   = 1'b0;
    case (state)
      mac_ctrl_pkg::rtx_idle, mac_ctrl_pkg::rtx_wait_tx_end: begin
        if (own_tx_end) begin
          // no ack expected, done at once
          done_ev    = !tx_need_ack;
          done_acked = !tx_need_ack;
        end else if (quit_retrans && retrans_in_progress) begin
          done_ev = 1'b1;
        end else begin
          start_ev = backoff_done && retry_pending;
        end
      end
      default: begin
        if ((state == mac_ctrl_pkg::rtx_wait_ack) && ack_ok) begin
          done_ev    = 1'b1;
          done_acked = 1'b1;
        end else if (timeout) begin
          done_ev  = last_try;
          retry_ev = !last_try;
        end
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state               <= mac_ctrl_pkg::rtx_idle;
      cnt                 <= '0;
      retries             <= '0;
      limit               <= '0;
      retry_pending       <= 1'b0;
      tx_try_complete     <= 1'b0;
      tx_status           <= '0;
      start_retrans       <= 1'b0;
      retrans_trigger     <= 1'b0;
      retrans_in_progress <= 1'b0;
    end else begin
      tx_try_complete <= done_ev;
      retrans_trigger <= retry_ev;
      start_retrans   <= start_ev;

      if (own_tx_end && (state inside {mac_ctrl_pkg::rtx_idle, mac_ctrl_pkg::rtx_wait_tx_end})) begin
        // tx_retry_limit is only valid with tx_done
        limit <= (cfg.max_retrans != '0) ? cfg.max_retrans : tx_retry_limit;
        if (tx_need_ack) retrans_in_progress <= 1'b1;
      end

      if (done_ev) begin
        tx_status.acked     <= done_acked;
        tx_status.retries   <= retries;
        retries             <= '0;
        retry_pending       <= 1'b0;
        retrans_in_progress <= 1'b0;
      end else if (retry_ev) begin
        retries       <= retries + 4'd1;
        retry_pending <= 1'b1;
      end else if (start_ev) begin
        retry_pending <= 1'b0;
      end

      case (state)
        mac_ctrl_pkg::rtx_idle, mac_ctrl_pkg::rtx_wait_tx_end: begin
          cnt <= '0;
          if (own_tx_end && tx_need_ack) begin
            state <= mac_ctrl_pkg::rtx_wait_sig;
          end else if (done_ev) begin
            state <= mac_ctrl_pkg::rtx_idle;
          end else if (start_ev) begin
            // retry goes out, wait for its tx_done
            state <= mac_ctrl_pkg::rtx_wait_tx_end;
          end
        end
        mac_ctrl_pkg::rtx_wait_sig: begin
          if (ack_sig) begin
            state <= mac_ctrl_pkg::rtx_wait_ack;
            cnt   <= '0;
          end else if (timeout) begin
            state <= mac_ctrl_pkg::rtx_idle;
          end else begin
            cnt <= cnt + 15'd1;
          end
        end
        mac_ctrl_pkg::rtx_wait_ack: begin
          if (done_ev || retry_ev) begin
            state <= mac_ctrl_pkg::rtx_idle;
          end else begin
            cnt <= cnt + 15'd1;
          end
        end
        default: state <= mac_ctrl_pkg::rtx_idle;
      endcase
    end
  end

  // an attempt either ends or retries, never both
  assert property (@(posedge clk) disable iff (!rstn) !(tx_try_complete && retrans_trigger));

endmodule

//--- verilog/rx_frame_classifier.sv
// received frame classifier
`timescale 1ns/1ps

module rx_frame_classifier (
  input  logic                     clk,
  input  logic                     rstn,
  input  mac_ctrl_pkg::rx_hdr_t    rx_hdr,
  input  logic                     sig_valid,
  input  logic                     fcs_strobe,
  input  logic                     fcs_valid,
  input  mac_ctrl_pkg::mac_addr_t  self_addr,
  output mac_ctrl_pkg::rx_evt_t    rx_evt,
  output logic                     rx_evt_valid,
  output logic                     ack_sig
);

  // rts is always 20 bytes
  localparam mac_ctrl_pkg::sig_len_t RTS_LEN = 12'd20;

  mac_ctrl_pkg::frame_kind_e kind;
  logic                      ack_len;

  assign ack_len = (rx_hdr.sig_len == mac_ctrl_pkg::ACK_LEN);

  always_comb begin
    kind = mac_ctrl_pkg::kind_other;
    case (rx_hdr.fc_type)
      // management, action no-ack excluded
      2'b00: if (rx_hdr.fc_subtype != 4'b1110) kind = mac_ctrl_pkg::kind_mgmt;
      2'b01: begin
        case (rx_hdr.fc_subtype)
          4'b1000: kind = mac_ctrl_pkg::kind_bar;
          4'b1010: kind = mac_ctrl_pkg::kind_pspoll;
          // length check drops corrupted control frames
          4'b1011: if (rx_hdr.sig_len == RTS_LEN) kind = mac_ctrl_pkg::kind_rts;
          4'b1101: if (ack_len) kind = mac_ctrl_pkg::kind_ack;
          default: kind = mac_ctrl_pkg::kind_other;
        endcase
      end
      2'b10: begin
        if (!rx_hdr.fc_subtype[3]) begin
          kind = mac_ctrl_pkg::kind_data;
        end else if (rx_hdr.qos_ack_policy == 2'b00) begin
          // qos data only counts with normal ack policy
          kind = mac_ctrl_pkg::kind_qos_data;
        end
      end
      default: kind = mac_ctrl_pkg::kind_other;
    endcase
  end

  // event payload, captured per fcs strobe
  always_ff @(posedge clk) begin
    if (fcs_strobe) begin
      rx_evt.kind      <= kind;
      rx_evt.to_self   <= (rx_hdr.addr1 == self_addr);
      rx_evt.fcs_ok    <= fcs_valid;
      rx_evt.more_frag <= rx_hdr.more_frag;
      rx_evt.duration  <= rx_hdr.duration;
      rx_evt.ta        <= rx_hdr.addr2;
      rx_evt.ack_sig   <= ack_len;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_evt_valid <= 1'b0;
      ack_sig      <= 1'b0;
    end else begin
      rx_evt_valid <= fcs_strobe;
      // signal field of a possible ack
      ack_sig      <= sig_valid && ack_len;
    end
  end

  // both events are single-cycle pulses
  assert property (@(posedge clk) disable iff (!rstn) rx_evt_valid |=> !rx_evt_valid);
  assert property (@(posedge clk) disable iff (!rstn) ack_sig |=> !ack_sig);

endmodule

//--- verilog/tx_control_top.sv
// tx control unit top level
`timescale 1ns/1ps

module tx_control_top (
  input  logic                        clk,
  input  logic                        rstn,
  // rx side
  input  mac_ctrl_pkg::rx_hdr_t       rx_hdr,
  input  logic                        sig_valid,
  input  logic                        fcs_strobe,
  input  logic                        fcs_valid,
  // tx side
  input  logic                        tx_done,
  input  logic                        tx_need_ack,
  input  mac_ctrl_pkg::retry_t        tx_retry_limit,
  input  logic                        backoff_done,
  input  logic                        quit_retrans,
  input  mac_ctrl_pkg::ctrl_cfg_t     cfg,
  // response descriptor out
  input  logic                        resp_ready,
  output logic                        resp_valid,
  output mac_ctrl_pkg::resp_frame_t   resp_frame,
  // attempt status
  output logic                        tx_try_complete,
  output mac_ctrl_pkg::tx_status_t    tx_status,
  output logic                        start_retrans,
  output logic                        retrans_trigger,
  output logic                        retrans_in_progress
);

  mac_ctrl_pkg::rx_evt_t   rx_evt;
  logic                    rx_evt_valid;
  logic                    ack_sig;
  mac_ctrl_pkg::resp_req_t req;
  logic                    req_valid;
  logic                    req_ready;
  logic                    resp_busy;

  rx_frame_classifier u_classifier (
    .clk          (clk),
    .rstn         (rstn),
    .rx_hdr       (rx_hdr),
    .sig_valid    (sig_valid),
    .fcs_strobe   (fcs_strobe),
    .fcs_valid    (fcs_valid),
    .self_addr    (cfg.self_addr),
    .rx_evt       (rx_evt),
    .rx_evt_valid (rx_evt_valid),
    .ack_sig      (ack_sig)
  );

  ack_responder u_responder (
    .clk          (clk),
    .rstn         (rstn),
    .rx_evt       (rx_evt),
    .rx_evt_valid (rx_evt_valid),
    .cfg          (cfg),
    .tx_done      (tx_done),
    .req_ready    (req_ready),
    .req          (req),
    .req_valid    (req_valid),
    .resp_busy    (resp_busy)
  );

  // busy flag keeps our own ack out of the retry logic
  retrans_controller u_retrans (
    .clk                 (clk),
    .rstn                (rstn),
    .tx_done             (tx_done),
    .tx_need_ack         (tx_need_ack),
    .tx_retry_limit      (tx_retry_limit),
    .resp_busy           (resp_busy),
    .ack_sig             (ack_sig),
    .rx_evt              (rx_evt),
    .rx_evt_valid        (rx_evt_valid),
    .backoff_done        (backoff_done),
    .quit_retrans        (quit_retrans),
    .cfg                 (cfg),
    .tx_try_complete     (tx_try_complete),
    .tx_status           (tx_status),
    .start_retrans       (start_retrans),
    .retrans_trigger     (retrans_trigger),
    .retrans_in_progress (retrans_in_progress)
  );

  resp_frame_builder u_builder (
    .clk        (clk),
    .rstn       (rstn),
    .req        (req),
    .req_valid  (req_valid),
    .resp_rate  (cfg.resp_rate),
    .resp_ready (resp_ready),
    .req_ready  (req_ready),
    .resp_frame (resp_frame),
    .resp_valid (resp_valid)
  );

endmodule
